// ==== cpu_consts.svh ====
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Strobe levels
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define READ_ENABLE    1'b1
`define READ_DISABLE   1'b0
`define WRITE_ENABLE   1'b1
`define WRITE_DISABLE  1'b0

`define ZERO_WORD      32'h0000_0000

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Access width codes (func3)
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Load encodings.
`define OP_LB          3'd0
`define OP_LH          3'd1
`define OP_LW          3'd2
`define OP_LBU         3'd4
`define OP_LHU         3'd5

// Store encodings overlap the signed loads.
`define OP_SB          3'd0
`define OP_SH          3'd1
`define OP_SW          3'd2

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Data memory size
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define DATA_RAM_WORDS 256  // 1 KiB of data RAM.

`endif

// ==== cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

  // Register file word, also used for addresses.
  typedef logic [31:0] reg_t;

  // Access width code from the instruction.
  typedef logic [2:0] func3_t;

  // Destination register number.
  typedef logic [4:0] regaddr_t;

  // Byte lane write enables, bit 3 is the top lane.
  typedef logic [3:0] byte_en_t;

endpackage

`default_nettype wire

// ==== data_ram.sv ====
`default_nettype none

`include "cpu_consts.svh"

module data_ram (
  input  logic              clk_i,
  input  logic              read_i,
  input  logic              write_i,
  input  cpu_pkg::byte_en_t byte_en_i,
  input  cpu_pkg::reg_t     addr_i,
  input  cpu_pkg::reg_t     wdata_i,

  output cpu_pkg::reg_t     rdata_o
);

  localparam int unsigned IDX_W = $clog2(`DATA_RAM_WORDS);

  cpu_pkg::reg_t    ram_q [`DATA_RAM_WORDS];
  logic [IDX_W-1:0] word_idx;
  cpu_pkg::reg_t    rdata_q;

  assign word_idx = addr_i[IDX_W+1:2];  // Word address, byte offset dropped.

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Byte lane writes
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk_i) begin
    for (int lane = 0; lane < 4; lane++) begin
      if (write_i && byte_en_i[lane]) begin
        ram_q[word_idx][lane*8 +: 8] <= wdata_i[lane*8 +: 8];
      end
    end
  end

  // Registered read, holds when idle.
  always_ff @(posedge clk_i) begin
    if (read_i) begin
      rdata_q <= ram_q[word_idx];
    end
  end

  assign rdata_o = rdata_q;

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+.
cpu_pkg.sv
mem.sv
data_ram.sv
load_align.sv
mem_wb_ctrl.sv
mem_access_top.sv
tb_mem_access.sv

// ==== load_align.sv ====
`default_nettype none

`include "cpu_consts.svh"

module load_align (
  input  cpu_pkg::reg_t   rdata_i,
  input  cpu_pkg::func3_t func3_i,
  input  logic [1:0]      offset_i,

  output cpu_pkg::reg_t   load_data_o
);

  logic [7:0]  byte_sel;
  logic [15:0] half_sel;

  // Byte picked by the low address bits.
  always_comb begin
    case (offset_i)
      2'b00:   byte_sel = rdata_i[7:0];
      2'b01:   byte_sel = rdata_i[15:8];
      2'b10:   byte_sel = rdata_i[23:16];
      default: byte_sel = rdata_i[31:24];
    endcase
  end

  // Halfword picked by bit 1 only.
  assign half_sel = offset_i[1] ? rdata_i[31:16] : rdata_i[15:0];

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Sign and zero extension
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    case (func3_i)
      `OP_LW: begin
        load_data_o = rdata_i;
      end
      `OP_LH: begin
        load_data_o = {{16{half_sel[15]}}, half_sel};
      end
      `OP_LHU: begin
        load_data_o = {16'b0, half_sel};
      end
      `OP_LB: begin
        load_data_o = {{24{byte_sel[7]}}, byte_sel};
      end
      `OP_LBU: begin
        load_data_o = {24'b0, byte_sel};
      end
      default: begin
        load_data_o = `ZERO_WORD;  // Reserved width codes.
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== mem.sv ====
`default_nettype none

`include "cpu_consts.svh"

module mem (
  input  logic              memrd_i,
  input  logic              memwr_i,
  input  cpu_pkg::reg_t     wreg_data_i,
  input  cpu_pkg::reg_t     wdata_i,
  input  logic              wb_mem2reg_i,
  input  cpu_pkg::func3_t   func3_i,

  output logic              data_read_o,
  output logic              data_write_o,
  output cpu_pkg::byte_en_t data_write_type_o,
  output cpu_pkg::reg_t     data_write_addr_o,
  output cpu_pkg::reg_t     data_out_o
);

  cpu_pkg::reg_t memaddr;

  assign memaddr = wreg_data_i;  // ALU result is the address.

  always_comb begin
    data_read_o       = `READ_DISABLE;
    data_write_o      = `WRITE_DISABLE;
    data_write_type_o = '0;
    data_write_addr_o = `ZERO_WORD;
    data_out_o        = `ZERO_WORD;

    if (memrd_i == `READ_ENABLE && memwr_i == `WRITE_DISABLE) begin  // Load.
      data_read_o       = `READ_ENABLE;
      data_write_addr_o = memaddr;
    end else if (memrd_i == `READ_DISABLE && memwr_i == `WRITE_ENABLE) begin  // Store.
      data_write_o      = `WRITE_ENABLE;
      data_write_addr_o = memaddr;

      // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
      // Lane select and data shift
      // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
      case (func3_i)
        `OP_SW: begin
          data_write_type_o = 4'b1111;
          data_out_o        = wdata_i;
        end
        `OP_SH: begin
          if (memaddr[1]) begin
            data_write_type_o = 4'b1100;  // Upper halfword.
            data_out_o        = {wdata_i[15:0], 16'b0};
          end else begin
            data_write_type_o = 4'b0011;  // Lower halfword.
            data_out_o        = {16'b0, wdata_i[15:0]};
          end
        end
        `OP_SB: begin
          case (memaddr[1:0])
            2'b00: begin
              data_write_type_o = 4'b0001;
              data_out_o        = {24'b0, wdata_i[7:0]};
            end
            2'b01: begin
              data_write_type_o = 4'b0010;
              data_out_o        = {16'b0, wdata_i[7:0], 8'b0};
            end
            2'b10: begin
              data_write_type_o = 4'b0100;
              data_out_o        = {8'b0, wdata_i[7:0], 16'b0};
            end
            default: begin
              data_write_type_o = 4'b1000;
              data_out_o        = {wdata_i[7:0], 24'b0};
            end
          endcase
        end
        default: begin
          // Unknown width writes nothing.
          data_write_type_o = 4'b0000;
          data_out_o        = wdata_i;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== mem_access_top.sv ====
`default_nettype none

module mem_access_top (
  input  logic              clk_i,
  input  logic              reset_i,
  input  logic              valid_i,
  input  logic              memrd_i,
  input  logic              memwr_i,
  input  cpu_pkg::reg_t     wreg_data_i,
  input  cpu_pkg::reg_t     wdata_i,
  input  logic              wb_mem2reg_i,
  input  cpu_pkg::func3_t   func3_i,
  input  logic              wreg_i,
  input  cpu_pkg::regaddr_t wd_i,

  output logic              wb_we_o,
  output cpu_pkg::regaddr_t wb_rd_o,
  output cpu_pkg::reg_t     wb_data_o
);

  logic              memrd_v;
  logic              memwr_v;
  logic              wreg_v;

  logic              ram_read;
  logic              ram_write;
  cpu_pkg::byte_en_t ram_byte_en;
  cpu_pkg::reg_t     ram_addr;
  cpu_pkg::reg_t     ram_wdata;
  cpu_pkg::reg_t     ram_rdata;

  cpu_pkg::func3_t   load_func3;
  logic [1:0]        load_offset;
  cpu_pkg::reg_t     load_data;

  // Qualify strobes with valid.
  assign {memrd_v, memwr_v, wreg_v} = {memrd_i, memwr_i, wreg_i} & {3{valid_i}};

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Request cycle
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  mem u_mem (
    .memrd_i           (memrd_v),
    .memwr_i           (memwr_v),
    .wreg_data_i       (wreg_data_i),
    .wdata_i           (wdata_i),
    .wb_mem2reg_i      (wb_mem2reg_i),
    .func3_i           (func3_i),
    .data_read_o       (ram_read),
    .data_write_o      (ram_write),
    .data_write_type_o (ram_byte_en),
    .data_write_addr_o (ram_addr),
    .data_out_o        (ram_wdata)
  );

  data_ram u_data_ram (
    .clk_i     (clk_i),
    .read_i    (ram_read),
    .write_i   (ram_write),
    .byte_en_i (ram_byte_en),
    .addr_i    (ram_addr),
    .wdata_i   (ram_wdata),
    .rdata_o   (ram_rdata)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Write-back cycle
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  load_align u_load_align (
    .rdata_i     (ram_rdata),
    .func3_i     (load_func3),
    .offset_i    (load_offset),
    .load_data_o (load_data)
  );

  mem_wb_ctrl u_mem_wb_ctrl (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .wreg_i        (wreg_v),
    .wd_i          (wd_i),
    .mem2reg_i     (wb_mem2reg_i),
    .func3_i       (func3_i),
    .alu_result_i  (wreg_data_i),
    .load_data_i   (load_data),
    .load_func3_o  (load_func3),
    .load_offset_o (load_offset),
    .wb_we_o       (wb_we_o),
    .wb_rd_o       (wb_rd_o),
    .wb_data_o     (wb_data_o)
  );

endmodule

`default_nettype wire

// ==== mem_wb_ctrl.sv ====
`default_nettype none

`include "cpu_consts.svh"

module mem_wb_ctrl (
  input  logic              clk_i,
  input  logic              reset_i,
  input  logic              wreg_i,
  input  cpu_pkg::regaddr_t wd_i,
  input  logic              mem2reg_i,
  input  cpu_pkg::func3_t   func3_i,
  input  cpu_pkg::reg_t     alu_result_i,
  input  cpu_pkg::reg_t     load_data_i,

  output cpu_pkg::func3_t   load_func3_o,
  output logic [1:0]        load_offset_o,
  output logic              wb_we_o,
  output cpu_pkg::regaddr_t wb_rd_o,
  output cpu_pkg::reg_t     wb_data_o
);

  logic              we_q;
  cpu_pkg::regaddr_t rd_q;
  logic              mem2reg_q;
  cpu_pkg::func3_t   func3_q;
  logic [1:0]        offset_q;
  cpu_pkg::reg_t     alu_q;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // In-flight instruction register
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      we_q      <= `WRITE_DISABLE;
      rd_q      <= '0;
      mem2reg_q <= 1'b0;
      func3_q   <= '0;
      offset_q  <= '0;
      alu_q     <= `ZERO_WORD;
    end else begin
      we_q      <= wreg_i;
      rd_q      <= wd_i;
      mem2reg_q <= mem2reg_i;
      func3_q   <= func3_i;
      offset_q  <= alu_result_i[1:0];  // Byte offset of the access.
      alu_q     <= alu_result_i;
    end
  end

  // Steer the aligner for the word now leaving the RAM.
  assign load_func3_o  = func3_q;
  assign load_offset_o = offset_q;

  // Write-back port.
  assign wb_we_o   = we_q;
  assign wb_rd_o   = rd_q;
  assign wb_data_o = mem2reg_q ? load_data_i : alu_q;  // Load or ALU result.

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the memory access stage testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --timescale 1ns/100ps \
  -f flist.f --top-module tb_mem_access \
  -Mdir obj_dir -o tb_mem_access
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_mem_access > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Simulation FAILED" "$LOG"; then
  exit 1
fi
if ! grep -q "Simulation PASSED" "$LOG"; then
  echo "No result line found in $LOG"
  exit 1
fi
exit 0

// ==== tb_mem_access.sv ====
`default_nettype none

`include "cpu_consts.svh"

module tb_mem_access;
  timeunit 1ns;
  timeprecision 100ps;

  localparam logic [1:0] KIND_ALU   = 2'd0;
  localparam logic [1:0] KIND_LOAD  = 2'd1;
  localparam logic [1:0] KIND_STORE = 2'd2;

  typedef struct packed {
    logic [1:0]        kind;
    logic              valid;
    cpu_pkg::func3_t   func3;
    cpu_pkg::reg_t     addr;
    cpu_pkg::reg_t     wdata;
    logic              mem2reg;
    logic              wreg;
    cpu_pkg::regaddr_t wd;
    logic              exp_we;
    cpu_pkg::regaddr_t exp_rd;
    cpu_pkg::reg_t     exp_data;
    logic              chk_data;  // Cleared when the data output is stale.
  } entry_t;

  logic              clk = 1'b0;
  logic              reset;
  logic              valid;
  logic              memrd;
  logic              memwr;
  cpu_pkg::reg_t     alu_result;
  cpu_pkg::reg_t     store_data;
  logic              mem2reg;
  cpu_pkg::func3_t   func3;
  logic              wreg;
  cpu_pkg::regaddr_t wd;
  logic              wb_we;
  cpu_pkg::regaddr_t wb_rd;
  cpu_pkg::reg_t     wb_data;

  entry_t        table_q[$];
  logic [7:0]    mem_model [1024];  // Byte image of the data RAM.
  logic [31:0]   rng_state = 32'hfa1;
  logic          table_ready = 1'b0;
  int            error_count = 0;
  int            check_count = 0;

  always #10 clk = ~clk;

  mem_access_top u_dut (
    .clk_i        (clk),
    .reset_i      (reset),
    .valid_i      (valid),
    .memrd_i      (memrd),
    .memwr_i      (memwr),
    .wreg_data_i  (alu_result),
    .wdata_i      (store_data),
    .wb_mem2reg_i (mem2reg),
    .func3_i      (func3),
    .wreg_i       (wreg),
    .wd_i         (wd),
    .wb_we_o      (wb_we),
    .wb_rd_o      (wb_rd),
    .wb_data_o    (wb_data)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Reference memory model
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic cpu_pkg::reg_t model_word(input cpu_pkg::reg_t a);
    return {mem_model[{a[9:2], 2'd3}], mem_model[{a[9:2], 2'd2}],
            mem_model[{a[9:2], 2'd1}], mem_model[{a[9:2], 2'd0}]};
  endfunction

  task automatic model_store(input cpu_pkg::func3_t f3, input cpu_pkg::reg_t a,
                             input cpu_pkg::reg_t d);
    case (f3)
      `OP_SW: begin
        mem_model[{a[9:2], 2'd0}] = d[7:0];
        mem_model[{a[9:2], 2'd1}] = d[15:8];
        mem_model[{a[9:2], 2'd2}] = d[23:16];
        mem_model[{a[9:2], 2'd3}] = d[31:24];
      end
      `OP_SH: begin
        mem_model[{a[9:2], a[1], 1'b0}] = d[7:0];
        mem_model[{a[9:2], a[1], 1'b1}] = d[15:8];
      end
      `OP_SB: mem_model[a[9:0]] = d[7:0];
      default: ;  // No lane written.
    endcase
  endtask

  function automatic cpu_pkg::reg_t model_load(input cpu_pkg::func3_t f3,
                                               input cpu_pkg::reg_t a);
    cpu_pkg::reg_t w;
    logic [7:0]    b;
    logic [15:0]   h;
    w = model_word(a);
    b = mem_model[a[9:0]];
    h = {mem_model[{a[9:2], a[1], 1'b1}], mem_model[{a[9:2], a[1], 1'b0}]};
    case (f3)
      `OP_LW:  return w;
      `OP_LH:  return {{16{h[15]}}, h};
      `OP_LHU: return {16'd0, h};
      `OP_LB:  return {{24{b[7]}}, b};
      `OP_LBU: return {24'd0, b};
      default: return `ZERO_WORD;
    endcase
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Table construction
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic add_op(input logic [1:0] kind, input logic v, input cpu_pkg::func3_t f3,
                        input cpu_pkg::reg_t a, input cpu_pkg::reg_t d, input logic m2r,
                        input logic wr, input cpu_pkg::regaddr_t rd);
    entry_t e;
    e.kind     = kind;
    e.valid    = v;
    e.func3    = f3;
    e.addr     = a;
    e.wdata    = d;
    e.mem2reg  = m2r;
    e.wreg     = wr;
    e.wd       = rd;
    e.exp_we   = v & wr;
    e.exp_rd   = rd;
    e.exp_data = m2r ? model_load(f3, a) : a;
    e.chk_data = !m2r || (v && kind == KIND_LOAD);
    if (v && kind == KIND_STORE) begin
      model_store(f3, a, d);
    end
    table_q.push_back(e);
  endtask

  task automatic add_alu(input cpu_pkg::reg_t a, input cpu_pkg::regaddr_t rd);
    add_op(KIND_ALU, 1'b1, `OP_LW, a, `ZERO_WORD, 1'b0, 1'b1, rd);
  endtask

  task automatic add_store(input cpu_pkg::func3_t f3, input cpu_pkg::reg_t a,
                           input cpu_pkg::reg_t d);
    add_op(KIND_STORE, 1'b1, f3, a, d, 1'b0, 1'b0, 5'd0);
  endtask

  task automatic add_load(input cpu_pkg::func3_t f3, input cpu_pkg::reg_t a,
                          input cpu_pkg::regaddr_t rd);
    add_op(KIND_LOAD, 1'b1, f3, a, `ZERO_WORD, 1'b1, 1'b1, rd);
  endtask

  task automatic build_table();
    cpu_pkg::reg_t   a;
    cpu_pkg::func3_t lf3;
    add_alu(32'h1234_5678, 5'd3);
    add_alu(32'hdead_beef, 5'd31);
    add_store(`OP_SW, 32'h0000_0040, 32'ha5a5_5a5a);
    add_load(`OP_LW, 32'h0000_0040, 5'd5);  // Load right after the store.
    add_store(`OP_SW, 32'h0000_0044, 32'h0f1e_2d3c);
    add_alu(32'h0000_0044, 5'd6);
    add_load(`OP_LW, 32'h0000_0044, 5'd7);
    add_store(`OP_SW, 32'h0000_0080, 32'h1122_3344);
    add_store(`OP_SW, 32'h0000_0084, 32'h5566_7788);
    add_store(`OP_SB, 32'h0000_0080, 32'hffff_ff80);
    add_load(`OP_LW, 32'h0000_0080, 5'd8);
    add_store(`OP_SB, 32'h0000_0081, 32'h0000_007f);
    add_load(`OP_LW, 32'h0000_0080, 5'd8);
    add_store(`OP_SB, 32'h0000_0082, 32'h1234_56c3);
    add_load(`OP_LW, 32'h0000_0080, 5'd8);
    add_store(`OP_SB, 32'h0000_0083, 32'h0000_0005);
    add_load(`OP_LW, 32'h0000_0080, 5'd8);
    add_store(`OP_SH, 32'h0000_0084, 32'habcd_8001);
    add_load(`OP_LW, 32'h0000_0084, 5'd9);
    add_store(`OP_SH, 32'h0000_0086, 32'h1234_7ffe);
    add_load(`OP_LW, 32'h0000_0084, 5'd9);
    for (int off = 0; off < 4; off++) begin
      add_load(`OP_LB, 32'h0000_0080 + off, 5'd10);
      add_load(`OP_LBU, 32'h0000_0080 + off, 5'd11);
    end
    for (int off = 0; off < 4; off += 2) begin
      add_load(`OP_LH, 32'h0000_0084 + off, 5'd12);
      add_load(`OP_LHU, 32'h0000_0084 + off, 5'd13);
    end
    // Reserved width codes and operations without valid.
    add_store(`OP_SW, 32'h0000_00c0, 32'h0bad_f00d);
    add_store(3'd3, 32'h0000_00c0, 32'hffff_ffff);
    add_store(3'd7, 32'h0000_00c1, 32'hffff_ffff);
    add_load(`OP_LW, 32'h0000_00c0, 5'd14);
    add_load(3'd3, 32'h0000_00c0, 5'd15);
    add_load(3'd6, 32'h0000_00c0, 5'd15);
    add_load(3'd7, 32'h0000_00c0, 5'd15);
    add_op(KIND_STORE, 1'b0, `OP_SW, 32'h0000_00c0, 32'h5555_5555, 1'b0, 1'b1, 5'd9);
    add_op(KIND_ALU, 1'b0, `OP_LW, 32'h0000_0123, `ZERO_WORD, 1'b0, 1'b1, 5'd4);
    add_op(KIND_LOAD, 1'b0, `OP_LW, 32'h0000_00c0, `ZERO_WORD, 1'b1, 1'b1, 5'd2);
    add_load(`OP_LW, 32'h0000_00c0, 5'd14);
    // Random region, each word written once before use.
    for (int w = 0; w < 16; w++) begin
      rng_state = lcg_next(rng_state);
      add_store(`OP_SW, {22'd0, 4'b0100, w[3:0], 2'b00}, rng_state);
    end
    for (int n = 0; n < 40; n++) begin
      rng_state = lcg_next(rng_state);
      a = {22'd0, 4'b0100, rng_state[9:6], rng_state[11:10]};
      case (rng_state[14:12])
        3'd0: lf3 = `OP_LB;
        3'd1: lf3 = `OP_LH;
        3'd3: lf3 = `OP_LBU;
        3'd4: lf3 = `OP_LHU;
        default: lf3 = `OP_LW;
      endcase
      case (rng_state[1:0])
        2'd0: add_alu(rng_state, rng_state[20:16]);
        2'd1: add_load(lf3, a, rng_state[20:16]);
        default: begin
          rng_state = lcg_next(rng_state);
          add_store({1'b0, rng_state[25:24]}, a, rng_state);  // SB, SH, SW or none.
        end
      endcase
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Compare tasks
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic check_data(input cpu_pkg::reg_t got, input cpu_pkg::reg_t exp,
                            input string what);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("ERR %0t: %s wb_data_o is %08h, expected %08h", $time, what, got, exp);
    end
  endtask

  task automatic check_rd(input cpu_pkg::regaddr_t got, input cpu_pkg::regaddr_t exp,
                          input string what);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("ERR %0t: %s wb_rd_o is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_we(input logic got, input logic exp, input string what);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("ERR %0t: %s wb_we_o is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic drive_entry(input entry_t e);
    valid      = e.valid;
    memrd      = (e.kind == KIND_LOAD);
    memwr      = (e.kind == KIND_STORE);
    alu_result = e.addr;
    store_data = e.wdata;
    mem2reg    = e.mem2reg;
    func3      = e.func3;
    wreg       = e.wreg;
    wd         = e.wd;
  endtask

  // Ends a run that stops making progress.
  initial begin
    wait (table_ready);
    #((table_q.size() + 20) * 20);
    $display("Timeout: the test table did not complete in the expected time");
    $display("Simulation FAILED");
    $finish;
  end

  initial begin
    int    errs_before;
    string tag;
    reset = 1'b1;
    drive_entry('0);
    wreg       = 1'b1;  // Busy fields under reset, valid low.
    wd         = 5'd31;
    alu_result = 32'hffff_ffff;
    build_table();
    table_ready = 1'b1;
    repeat (2) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    check_we(wb_we, 1'b0, "reset");
    check_rd(wb_rd, 5'd0, "reset");
    check_data(wb_data, `ZERO_WORD, "reset");
    $display("test reset: %s", (error_count == 0) ? "ok" : "mismatch");
    for (int i = 0; i <= table_q.size(); i++) begin
      if (i > 0) begin
        errs_before = error_count;
        tag = $sformatf("entry %0d", i - 1);
        check_we(wb_we, table_q[i-1].exp_we, tag);
        check_rd(wb_rd, table_q[i-1].exp_rd, tag);
        if (table_q[i-1].chk_data) begin
          check_data(wb_data, table_q[i-1].exp_data, tag);
        end
        $display("test %0d kind %0d func3 %0d addr %08h: %s", i - 1, table_q[i-1].kind,
                 table_q[i-1].func3, table_q[i-1].addr,
                 (error_count == errs_before) ? "ok" : "mismatch");
      end
      if (i < table_q.size()) begin
        drive_entry(table_q[i]);
      end else begin
        drive_entry('0);
      end
      @(negedge clk);
    end
    $display("Done: %0d tests, %0d checks, %0d errors", table_q.size() + 1, check_count,
             error_count);
    if (error_count == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
